//--- verilog/mcore_settings.svh
// ==========================================================
// widths and codes shared by the core and memory sides
// bank depth sets how many address bits the bank decodes
// ==========================================================
`ifndef MCORE_SETTINGS_SVH
`define MCORE_SETTINGS_SVH

// message field widths
`define MCORE_OPAQUE_NBITS     8
`define MCORE_ADDR_NBITS       32
`define MCORE_PROC_DATA_NBITS  32
`define MCORE_MEM_DATA_NBITS   128
`define MCORE_TYPE_NBITS       3

// core length 0 means a full 4-byte word
`define MCORE_PROC_LEN_NBITS   2

// memory length 0 means a full 16-byte line
`define MCORE_MEM_LEN_NBITS    4

// message type codes
`define MCORE_TYPE_READ        3'd0
`define MCORE_TYPE_WRITE       3'd1

// bank depth in lines, 256 bytes in total
`define MCORE_MEM_LINES        16

`endif

//--- verilog/proc_msg_pkg.sv
// ==========================================================
// core-side message data types
// ==========================================================
`default_nettype none

`include "mcore_settings.svh"

package proc_msg_pkg;

	// one core data word, whole or by bytes
	typedef union packed {
		logic [`MCORE_PROC_DATA_NBITS-1:0]          word;
		logic [`MCORE_PROC_DATA_NBITS/8-1:0][7:0]   bytes;
	} proc_word_u;

endpackage

`default_nettype wire

//--- verilog/mem_msg_pkg.sv
// ==========================================================
// memory-side message data types
// byte 0 and word 0 are the low end of the line
// ==========================================================
`default_nettype none

`include "mcore_settings.svh"

package mem_msg_pkg;

	// one bank line, by bytes or by 32-bit words
	typedef union packed {
		logic [`MCORE_MEM_DATA_NBITS/8-1:0][7:0]    bytes;
		logic [`MCORE_MEM_DATA_NBITS/32-1:0][31:0]  words;
	} mem_line_u;

endpackage

`default_nettype wire

//--- verilog/proc2mem_trans.sv
// ==========================================================
// core <-> line format translation, purely combinational
// reads carry zero line data, responses always have len 0
// ==========================================================
`default_nettype none

`include "mcore_settings.svh"

module proc2mem_trans
	import proc_msg_pkg::*;
	import mem_msg_pkg::*;
(
	// request from the core
	input  logic [`MCORE_TYPE_NBITS-1:0]      proc_req_type,
	input  logic [`MCORE_OPAQUE_NBITS-1:0]    proc_req_opaque,
	input  logic [`MCORE_ADDR_NBITS-1:0]      proc_req_addr,
	input  logic [`MCORE_PROC_LEN_NBITS-1:0]  proc_req_len,
	input  logic [`MCORE_PROC_DATA_NBITS-1:0] proc_req_data,

	// response from the memory side
	input  logic [`MCORE_TYPE_NBITS-1:0]      mem_resp_type,
	input  logic [`MCORE_OPAQUE_NBITS-1:0]    mem_resp_opaque,
	input  logic [`MCORE_MEM_DATA_NBITS-1:0]  mem_resp_data,

	// widened request
	output logic [`MCORE_TYPE_NBITS-1:0]      mem_req_type,
	output logic [`MCORE_OPAQUE_NBITS-1:0]    mem_req_opaque,
	output logic [`MCORE_ADDR_NBITS-1:0]      mem_req_addr,
	output logic [`MCORE_MEM_LEN_NBITS-1:0]   mem_req_len,
	output logic [`MCORE_MEM_DATA_NBITS-1:0]  mem_req_data,

	// narrowed response
	output logic [`MCORE_TYPE_NBITS-1:0]      proc_resp_type,
	output logic [`MCORE_OPAQUE_NBITS-1:0]    proc_resp_opaque,
	output logic [`MCORE_PROC_LEN_NBITS-1:0]  proc_resp_len,
	output logic [`MCORE_PROC_DATA_NBITS-1:0] proc_resp_data
);

	proc_word_u req_word;
	proc_word_u resp_word;
	mem_line_u  req_line;
	mem_line_u  resp_line;

	// ==========================================================
	// request path
	// ==========================================================
	assign mem_req_type   = proc_req_type;
	assign mem_req_opaque = proc_req_opaque;
	assign mem_req_addr   = proc_req_addr;

	// 0 means a full word on the core side, so spell it out as 4
	assign mem_req_len = (proc_req_len == '0) ? `MCORE_MEM_LEN_NBITS'(4)
		: `MCORE_MEM_LEN_NBITS'(proc_req_len);

	assign req_word.word = proc_req_data;

	// write bytes land in the low word, the rest of the line stays zero
	always_comb begin
		req_line = '0;
		if (proc_req_type != `MCORE_TYPE_READ)
			req_line.bytes[3:0] = req_word.bytes;
	end

	assign mem_req_data = req_line;

	// ==========================================================
	// response path
	// ==========================================================
	assign resp_line        = mem_resp_data;
	assign resp_word.word   = resp_line.words[0];

	assign proc_resp_type   = mem_resp_type;
	assign proc_resp_opaque = mem_resp_opaque;
	assign proc_resp_len    = '0;
	assign proc_resp_data   = resp_word.word;

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
// ==========================================================
// two-core arbiter for one bank with a 1-cycle latency
// no back-pressure, each core keeps one request outstanding
// ==========================================================
`default_nettype none

`include "mcore_settings.svh"

module mem_arbiter
	import mem_msg_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst_n,

	// core 0 request
	input  logic                              req0_val,
	input  logic [`MCORE_TYPE_NBITS-1:0]      req0_type,
	input  logic [`MCORE_OPAQUE_NBITS-1:0]    req0_opaque,
	input  logic [`MCORE_ADDR_NBITS-1:0]      req0_addr,
	input  logic [`MCORE_MEM_LEN_NBITS-1:0]   req0_len,
	input  logic [`MCORE_MEM_DATA_NBITS-1:0]  req0_data,

	// core 1 request
	input  logic                              req1_val,
	input  logic [`MCORE_TYPE_NBITS-1:0]      req1_type,
	input  logic [`MCORE_OPAQUE_NBITS-1:0]    req1_opaque,
	input  logic [`MCORE_ADDR_NBITS-1:0]      req1_addr,
	input  logic [`MCORE_MEM_LEN_NBITS-1:0]   req1_len,
	input  logic [`MCORE_MEM_DATA_NBITS-1:0]  req1_data,

	// bank response
	input  logic                              bank_resp_val,
	input  logic [`MCORE_TYPE_NBITS-1:0]      bank_resp_type,
	input  logic [`MCORE_OPAQUE_NBITS-1:0]    bank_resp_opaque,
	input  logic [`MCORE_MEM_DATA_NBITS-1:0]  bank_resp_data,

	// bank request
	output logic                              bank_req_val,
	output logic [`MCORE_TYPE_NBITS-1:0]      bank_req_type,
	output logic [`MCORE_OPAQUE_NBITS-1:0]    bank_req_opaque,
	output logic [`MCORE_ADDR_NBITS-1:0]      bank_req_addr,
	output logic [`MCORE_MEM_LEN_NBITS-1:0]   bank_req_len,
	output logic [`MCORE_MEM_DATA_NBITS-1:0]  bank_req_data,

	// responses, fields shared by both cores
	output logic                              resp0_val,
	output logic                              resp1_val,
	output logic [`MCORE_TYPE_NBITS-1:0]      resp_type,
	output logic [`MCORE_OPAQUE_NBITS-1:0]    resp_opaque,
	output logic [`MCORE_MEM_DATA_NBITS-1:0]  resp_data
);

	// incoming requests by core index
	logic [1:0]                      in_val;
	logic [`MCORE_TYPE_NBITS-1:0]    in_type   [2];
	logic [`MCORE_OPAQUE_NBITS-1:0]  in_opaque [2];
	logic [`MCORE_ADDR_NBITS-1:0]    in_addr   [2];
	logic [`MCORE_MEM_LEN_NBITS-1:0] in_len    [2];
	mem_line_u                       in_data   [2];

	// one holding slot per core
	logic [1:0]                      slot_full;
	logic [`MCORE_TYPE_NBITS-1:0]    slot_type   [2];
	logic [`MCORE_OPAQUE_NBITS-1:0]  slot_opaque [2];
	logic [`MCORE_ADDR_NBITS-1:0]    slot_addr   [2];
	logic [`MCORE_MEM_LEN_NBITS-1:0] slot_len    [2];
	mem_line_u                       slot_data   [2];

	// round-robin pointer, granted core, and owner of the bank response
	logic rr_ptr;
	logic grant;
	logic resp_owner;

	assign in_val       = {req1_val, req0_val};
	assign in_type[0]   = req0_type;
	assign in_type[1]   = req1_type;
	assign in_opaque[0] = req0_opaque;
	assign in_opaque[1] = req1_opaque;
	assign in_addr[0]   = req0_addr;
	assign in_addr[1]   = req1_addr;
	assign in_len[0]    = req0_len;
	assign in_len[1]    = req1_len;
	assign in_data[0]   = req0_data;
	assign in_data[1]   = req1_data;

	// ==========================================================
	// grant and bank request
	// ==========================================================
	// pointer only matters when both slots wait
	always_comb begin
		if (slot_full == 2'b11)
			grant = rr_ptr;
		else
			grant = slot_full[1];
	end

	assign bank_req_val    = |slot_full;
	assign bank_req_type   = slot_type[grant];
	assign bank_req_opaque = slot_opaque[grant];
	assign bank_req_addr   = slot_addr[grant];
	assign bank_req_len    = slot_len[grant];
	assign bank_req_data   = slot_data[grant];

	// ==========================================================
	// slot and pointer state
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_full  <= '0;
			rr_ptr     <= 1'b0;
			resp_owner <= 1'b0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (in_val[i])
					slot_full[i] <= 1'b1;
				else if (bank_req_val && grant == 1'(i))
					slot_full[i] <= 1'b0;
			end
			// the other core goes first next time
			if (bank_req_val) begin
				rr_ptr     <= ~grant;
				resp_owner <= grant;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (in_val[i]) begin
				slot_type[i]   <= in_type[i];
				slot_opaque[i] <= in_opaque[i];
				slot_addr[i]   <= in_addr[i];
				slot_len[i]    <= in_len[i];
				slot_data[i]   <= in_data[i];
			end
		end
	end

	// ==========================================================
	// response routing
	// ==========================================================
	assign resp0_val   = bank_resp_val && !resp_owner;
	assign resp1_val   = bank_resp_val && resp_owner;
	assign resp_type   = bank_resp_type;
	assign resp_opaque = bank_resp_opaque;
	assign resp_data   = bank_resp_data;

endmodule

`default_nettype wire

//--- verilog/mem_bank.sv
// ==========================================================
// single-port line memory, response one cycle after request
// offset + len must stay within the line, upper addr ignored
// ==========================================================
`default_nettype none

`include "mcore_settings.svh"

module mem_bank
	import mem_msg_pkg::*;
(
	input  logic                              clk,
	input  logic                              rst_n,

	input  logic                              req_val,
	input  logic [`MCORE_TYPE_NBITS-1:0]      req_type,
	input  logic [`MCORE_OPAQUE_NBITS-1:0]    req_opaque,
	input  logic [`MCORE_ADDR_NBITS-1:0]      req_addr,
	input  logic [`MCORE_MEM_LEN_NBITS-1:0]   req_len,
	input  logic [`MCORE_MEM_DATA_NBITS-1:0]  req_data,

	output logic                              resp_val,
	output logic [`MCORE_TYPE_NBITS-1:0]      resp_type,
	output logic [`MCORE_OPAQUE_NBITS-1:0]    resp_opaque,
	output logic [`MCORE_MEM_DATA_NBITS-1:0]  resp_data
);

	localparam int LINE_BYTES = `MCORE_MEM_DATA_NBITS / 8;
	localparam int OFF_NBITS  = $clog2(LINE_BYTES);
	localparam int IDX_NBITS  = $clog2(`MCORE_MEM_LINES);

	mem_line_u mem [`MCORE_MEM_LINES];

	logic [IDX_NBITS-1:0]  idx;
	logic [OFF_NBITS-1:0]  offset;
	logic [OFF_NBITS:0]    nbytes;
	logic [LINE_BYTES-1:0] len_mask;
	logic [LINE_BYTES-1:0] wr_mask;
	mem_line_u             wr_line;
	mem_line_u             rd_line;
	logic                  is_write;

	// ==========================================================
	// address decode and byte masks
	// ==========================================================
	assign idx      = req_addr[OFF_NBITS +: IDX_NBITS];
	assign offset   = req_addr[OFF_NBITS-1:0];
	assign is_write = (req_type == `MCORE_TYPE_WRITE);

	// len 0 is a whole line
	assign nbytes = (req_len == '0) ? (OFF_NBITS+1)'(LINE_BYTES)
		: (OFF_NBITS+1)'(req_len);

	always_comb begin
		for (int b = 0; b < LINE_BYTES; b++)
			len_mask[b] = (b < nbytes);
	end

	// write bytes move up to the offset, read bytes move down from it
	assign wr_mask = len_mask << offset;
	assign wr_line = req_data << {offset, 3'b000};

	always_comb begin
		rd_line = mem[idx] >> {offset, 3'b000};
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (!len_mask[b])
				rd_line.bytes[b] = 8'h00;
		end
	end

	// ==========================================================
	// storage
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `MCORE_MEM_LINES; i++)
				mem[i] <= '0;
		end else if (req_val && is_write) begin
			for (int b = 0; b < LINE_BYTES; b++) begin
				if (wr_mask[b])
					mem[idx].bytes[b] <= wr_line.bytes[b];
			end
		end
	end

	// ==========================================================
	// response register
	// ==========================================================
	always_ff @(posedge clk) begin
		if (!rst_n)
			resp_val <= 1'b0;
		else
			resp_val <= req_val;
	end

	// writes answer with zero data
	always_ff @(posedge clk) begin
		if (req_val) begin
			resp_type   <= req_type;
			resp_opaque <= req_opaque;
			resp_data   <= is_write ? '0 : rd_line;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mcore_mem_sys.sv
// ==========================================================
// two cores sharing one bank, request to response 2-3 cycles
// each core keeps at most one request outstanding
// ==========================================================
`default_nettype none

`include "mcore_settings.svh"

module mcore_mem_sys (
	input  logic                              clk,
	input  logic                              rst_n,

	// core 0
	input  logic                              core0_req_val,
	input  logic [`MCORE_TYPE_NBITS-1:0]      core0_req_type,
	input  logic [`MCORE_OPAQUE_NBITS-1:0]    core0_req_opaque,
	input  logic [`MCORE_ADDR_NBITS-1:0]      core0_req_addr,
	input  logic [`MCORE_PROC_LEN_NBITS-1:0]  core0_req_len,
	input  logic [`MCORE_PROC_DATA_NBITS-1:0] core0_req_data,
	output logic                              core0_resp_val,
	output logic [`MCORE_TYPE_NBITS-1:0]      core0_resp_type,
	output logic [`MCORE_OPAQUE_NBITS-1:0]    core0_resp_opaque,
	output logic [`MCORE_PROC_LEN_NBITS-1:0]  core0_resp_len,
	output logic [`MCORE_PROC_DATA_NBITS-1:0] core0_resp_data,

	// core 1
	input  logic                              core1_req_val,
	input  logic [`MCORE_TYPE_NBITS-1:0]      core1_req_type,
	input  logic [`MCORE_OPAQUE_NBITS-1:0]    core1_req_opaque,
	input  logic [`MCORE_ADDR_NBITS-1:0]      core1_req_addr,
	input  logic [`MCORE_PROC_LEN_NBITS-1:0]  core1_req_len,
	input  logic [`MCORE_PROC_DATA_NBITS-1:0] core1_req_data,
	output logic                              core1_resp_val,
	output logic [`MCORE_TYPE_NBITS-1:0]      core1_resp_type,
	output logic [`MCORE_OPAQUE_NBITS-1:0]    core1_resp_opaque,
	output logic [`MCORE_PROC_LEN_NBITS-1:0]  core1_resp_len,
	output logic [`MCORE_PROC_DATA_NBITS-1:0] core1_resp_data
);

	// widened requests into the arbiter
	logic [`MCORE_TYPE_NBITS-1:0]     m0_req_type,   m1_req_type;
	logic [`MCORE_OPAQUE_NBITS-1:0]   m0_req_opaque, m1_req_opaque;
	logic [`MCORE_ADDR_NBITS-1:0]     m0_req_addr,   m1_req_addr;
	logic [`MCORE_MEM_LEN_NBITS-1:0]  m0_req_len,    m1_req_len;
	logic [`MCORE_MEM_DATA_NBITS-1:0] m0_req_data,   m1_req_data;

	// arbiter response, seen by both translators
	logic [`MCORE_TYPE_NBITS-1:0]     arb_resp_type;
	logic [`MCORE_OPAQUE_NBITS-1:0]   arb_resp_opaque;
	logic [`MCORE_MEM_DATA_NBITS-1:0] arb_resp_data;

	// arbiter <-> bank
	logic                             bank_req_val;
	logic [`MCORE_TYPE_NBITS-1:0]     bank_req_type;
	logic [`MCORE_OPAQUE_NBITS-1:0]   bank_req_opaque;
	logic [`MCORE_ADDR_NBITS-1:0]     bank_req_addr;
	logic [`MCORE_MEM_LEN_NBITS-1:0]  bank_req_len;
	logic [`MCORE_MEM_DATA_NBITS-1:0] bank_req_data;
	logic                             bank_resp_val;
	logic [`MCORE_TYPE_NBITS-1:0]     bank_resp_type;
	logic [`MCORE_OPAQUE_NBITS-1:0]   bank_resp_opaque;
	logic [`MCORE_MEM_DATA_NBITS-1:0] bank_resp_data;

	proc2mem_trans i_trans0 (
		.proc_req_type(core0_req_type), .proc_req_opaque(core0_req_opaque),
		.proc_req_addr(core0_req_addr), .proc_req_len(core0_req_len),
		.proc_req_data(core0_req_data),
		.mem_resp_type(arb_resp_type), .mem_resp_opaque(arb_resp_opaque),
		.mem_resp_data(arb_resp_data),
		.mem_req_type(m0_req_type), .mem_req_opaque(m0_req_opaque),
		.mem_req_addr(m0_req_addr), .mem_req_len(m0_req_len), .mem_req_data(m0_req_data),
		.proc_resp_type(core0_resp_type), .proc_resp_opaque(core0_resp_opaque),
		.proc_resp_len(core0_resp_len), .proc_resp_data(core0_resp_data)
	);

	proc2mem_trans i_trans1 (
		.proc_req_type(core1_req_type), .proc_req_opaque(core1_req_opaque),
		.proc_req_addr(core1_req_addr), .proc_req_len(core1_req_len),
		.proc_req_data(core1_req_data),
		.mem_resp_type(arb_resp_type), .mem_resp_opaque(arb_resp_opaque),
		.mem_resp_data(arb_resp_data),
		.mem_req_type(m1_req_type), .mem_req_opaque(m1_req_opaque),
		.mem_req_addr(m1_req_addr), .mem_req_len(m1_req_len), .mem_req_data(m1_req_data),
		.proc_resp_type(core1_resp_type), .proc_resp_opaque(core1_resp_opaque),
		.proc_resp_len(core1_resp_len), .proc_resp_data(core1_resp_data)
	);

	mem_arbiter i_arb (
		.clk(clk), .rst_n(rst_n),
		.req0_val(core0_req_val), .req0_type(m0_req_type), .req0_opaque(m0_req_opaque),
		.req0_addr(m0_req_addr), .req0_len(m0_req_len), .req0_data(m0_req_data),
		.req1_val(core1_req_val), .req1_type(m1_req_type), .req1_opaque(m1_req_opaque),
		.req1_addr(m1_req_addr), .req1_len(m1_req_len), .req1_data(m1_req_data),
		.bank_resp_val(bank_resp_val), .bank_resp_type(bank_resp_type),
		.bank_resp_opaque(bank_resp_opaque), .bank_resp_data(bank_resp_data),
		.bank_req_val(bank_req_val), .bank_req_type(bank_req_type),
		.bank_req_opaque(bank_req_opaque), .bank_req_addr(bank_req_addr),
		.bank_req_len(bank_req_len), .bank_req_data(bank_req_data),
		.resp0_val(core0_resp_val), .resp1_val(core1_resp_val),
		.resp_type(arb_resp_type), .resp_opaque(arb_resp_opaque),
		.resp_data(arb_resp_data)
	);

	mem_bank i_bank (
		.clk(clk), .rst_n(rst_n),
		.req_val(bank_req_val), .req_type(bank_req_type), .req_opaque(bank_req_opaque),
		.req_addr(bank_req_addr), .req_len(bank_req_len), .req_data(bank_req_data),
		.resp_val(bank_resp_val), .resp_type(bank_resp_type),
		.resp_opaque(bank_resp_opaque), .resp_data(bank_resp_data)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clkgen.sv
// ==========================================================
// free-running testbench clock, starts low, 4 ns period
// ==========================================================
`default_nettype none

module tb_clkgen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clk = 1'b0;

	always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

//--- testbench/mcore_mem_sys_chk.sv
// ==========================================================
// timing assertions bound into every mem_arbiter instance
// ==========================================================
`default_nettype none

module mcore_mem_sys_chk (
	input logic       clk,
	input logic       rst_n,
	input logic       req0_val,
	input logic       req1_val,
	input logic [1:0] slot_full,
	input logic       bank_req_val,
	input logic       bank_resp_val,
	input logic       resp0_val,
	input logic       resp1_val
);
	timeunit 1ns;
	timeprecision 100ps;

	// one core at a time, and only the core whose slot the bank just emptied
	a_resp_route0: assert property (@(posedge clk) disable iff (!rst_n)
		resp0_val |-> (!resp1_val && $past(slot_full[0]) && !slot_full[0]))
		else $error("resp0_val high without a core 0 request just served");

	a_resp_route1: assert property (@(posedge clk) disable iff (!rst_n)
		resp1_val |-> (!resp0_val && $past(slot_full[1]) && !slot_full[1]))
		else $error("resp1_val high without a core 1 request just served");

	// bank answers every request exactly one cycle later
	a_bank_latency: assert property (@(posedge clk) disable iff (!rst_n)
		bank_resp_val == $past(bank_req_val))
		else $error("bank_resp_val does not follow bank_req_val by one cycle");

	// a core may not issue while its slot still holds a request
	a_one_outstanding0: assert property (@(posedge clk) disable iff (!rst_n)
		req0_val |-> !slot_full[0])
		else $error("core 0 issued a request with one still outstanding");

	a_one_outstanding1: assert property (@(posedge clk) disable iff (!rst_n)
		req1_val |-> !slot_full[1])
		else $error("core 1 issued a request with one still outstanding");

endmodule

bind mem_arbiter mcore_mem_sys_chk i_chk (
	.clk(clk), .rst_n(rst_n), .req0_val(req0_val), .req1_val(req1_val),
	.slot_full(slot_full), .bank_req_val(bank_req_val), .bank_resp_val(bank_resp_val),
	.resp0_val(resp0_val), .resp1_val(resp1_val)
);

`default_nettype wire

//--- testbench/tb_mcore_mem_sys.sv
// ==========================================================
// directed and random traffic from two cores, one outstanding
// per core; expected values come from a byte-level model
// ==========================================================
`default_nettype none

`include "mcore_settings.svh"

module tb_mcore_mem_sys
	import proc_msg_pkg::*;
	import mem_msg_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [`MCORE_TYPE_NBITS-1:0]      typ;
		logic [`MCORE_OPAQUE_NBITS-1:0]    opaque;
		logic [`MCORE_ADDR_NBITS-1:0]      addr;
		logic [`MCORE_PROC_LEN_NBITS-1:0]  len;
		logic [`MCORE_PROC_DATA_NBITS-1:0] data;
	} req_rec_t;

	logic                              clk;
	logic                              rst_n;
	logic                              core0_req_val;
	logic [`MCORE_TYPE_NBITS-1:0]      core0_req_type;
	logic [`MCORE_OPAQUE_NBITS-1:0]    core0_req_opaque;
	logic [`MCORE_ADDR_NBITS-1:0]      core0_req_addr;
	logic [`MCORE_PROC_LEN_NBITS-1:0]  core0_req_len;
	logic [`MCORE_PROC_DATA_NBITS-1:0] core0_req_data;
	logic                              core0_resp_val;
	logic [`MCORE_TYPE_NBITS-1:0]      core0_resp_type;
	logic [`MCORE_OPAQUE_NBITS-1:0]    core0_resp_opaque;
	logic [`MCORE_PROC_LEN_NBITS-1:0]  core0_resp_len;
	logic [`MCORE_PROC_DATA_NBITS-1:0] core0_resp_data;
	logic                              core1_req_val;
	logic [`MCORE_TYPE_NBITS-1:0]      core1_req_type;
	logic [`MCORE_OPAQUE_NBITS-1:0]    core1_req_opaque;
	logic [`MCORE_ADDR_NBITS-1:0]      core1_req_addr;
	logic [`MCORE_PROC_LEN_NBITS-1:0]  core1_req_len;
	logic [`MCORE_PROC_DATA_NBITS-1:0] core1_req_data;
	logic                              core1_resp_val;
	logic [`MCORE_TYPE_NBITS-1:0]      core1_resp_type;
	logic [`MCORE_OPAQUE_NBITS-1:0]    core1_resp_opaque;
	logic [`MCORE_PROC_LEN_NBITS-1:0]  core1_resp_len;
	logic [`MCORE_PROC_DATA_NBITS-1:0] core1_resp_data;

	// shadow of the bank, and requests waiting for a response
	mem_line_u   ref_lines [`MCORE_MEM_LINES];
	req_rec_t    pend_q0 [$];
	req_rec_t    pend_q1 [$];
	// rising edges seen, and the edge of each core's latest response
	int          clk_count = 0;
	int          resp_cycle [2];
	int          seq0 = 0;
	int          seq1 = 0;
	logic [31:0] lcg_state = 32'h5c1cdc8f;

	tb_clkgen i_clkgen (.clk(clk));

	mcore_mem_sys i_dut (.*);

	// ==========================================================
	// helpers
	// ==========================================================
	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int pending(input int core);
		return (core == 0) ? pend_q0.size() : pend_q1.size();
	endfunction

	// core id in the top bit keeps the two tag spaces apart
	function automatic logic [7:0] next_opaque(input int core);
		logic [7:0] tag;
		if (core == 0) begin
			tag = {1'b0, 7'(seq0)};
			seq0++;
		end else begin
			tag = {1'b1, 7'(seq1)};
			seq1++;
		end
		return tag;
	endfunction

	function automatic req_rec_t make_req(input int core, input logic [2:0] typ,
		input logic [31:0] addr, input logic [1:0] len, input logic [31:0] data);
		req_rec_t rec;
		rec.typ    = typ;
		rec.opaque = next_opaque(core);
		rec.addr   = addr;
		rec.len    = len;
		rec.data   = data;
		return rec;
	endfunction

	// random traffic stays in lines 4..7 so reads often hit earlier writes
	function automatic req_rec_t random_req(input int core);
		logic [31:0] r;
		logic [31:0] addr;
		logic [1:0]  len;
		logic [2:0]  typ;
		int          nbytes;
		int          off;
		r      = lcg_next();
		typ    = r[31] ? `MCORE_TYPE_WRITE : `MCORE_TYPE_READ;
		len    = r[29:28];
		nbytes = (len == 2'd0) ? 4 : int'(len);
		off    = int'(r[27:12]) % (17 - nbytes);
		addr   = lcg_next();
		addr[7:0] = {2'b01, r[9:8], 4'(off)};
		return make_req(core, typ, addr, len, lcg_next());
	endfunction

	// ==========================================================
	// reference model
	// ==========================================================
	// applied in response order, which is the bank's own order
	function automatic proc_word_u ref_access(input req_rec_t rec);
		proc_word_u wr;
		proc_word_u result;
		int         line;
		int         offset;
		int         nbytes;
		wr.word     = rec.data;
		result.word = '0;
		line   = int'((rec.addr >> 4) % `MCORE_MEM_LINES);
		offset = int'(rec.addr[3:0]);
		nbytes = (rec.len == 2'd0) ? 4 : int'(rec.len);
		for (int b = 0; b < nbytes; b++) begin
			if (rec.typ == `MCORE_TYPE_WRITE)
				ref_lines[line].bytes[offset + b] = wr.bytes[b];
			else
				result.bytes[b] = ref_lines[line].bytes[offset + b];
		end
		return result;
	endfunction

	// ==========================================================
	// compare tasks
	// ==========================================================
	task automatic check_data(input string name, input proc_word_u got, input proc_word_u exp);
		if (got.word !== exp.word) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got.word, exp.word);
			stop_run();
		end
	endtask

	task automatic check_opaque(input string name, input logic [`MCORE_OPAQUE_NBITS-1:0] got,
		input logic [`MCORE_OPAQUE_NBITS-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_type(input string name, input logic [`MCORE_TYPE_NBITS-1:0] got,
		input logic [`MCORE_TYPE_NBITS-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_len(input string name, input logic [`MCORE_PROC_LEN_NBITS-1:0] got,
		input logic [`MCORE_PROC_LEN_NBITS-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_resp(input int core, input logic [2:0] typ, input logic [7:0] opq,
		input logic [1:0] len, input proc_word_u data);
		req_rec_t   rec;
		proc_word_u exp;
		string      pfx;
		pfx = $sformatf("core%0d_resp", core);
		if (pending(core) == 0) begin
			$display("core %0d gave a response with no request outstanding at %0t",
				core, $time);
			stop_run();
		end else begin
			if (core == 0)
				rec = pend_q0.pop_front();
			else
				rec = pend_q1.pop_front();
			exp = ref_access(rec);
			check_type({pfx, "_type"}, typ, rec.typ);
			check_opaque({pfx, "_opaque"}, opq, rec.opaque);
			check_len({pfx, "_len"}, len, 2'd0);
			check_data({pfx, "_data"}, data, exp);
			resp_cycle[core] = clk_count;
		end
	endtask

	// outputs come from registers, so the rising edge sees settled values
	always @(posedge clk) begin
		clk_count++;
		if (rst_n) begin
			if (core0_resp_val)
				check_resp(0, core0_resp_type, core0_resp_opaque, core0_resp_len,
					core0_resp_data);
			if (core1_resp_val)
				check_resp(1, core1_resp_type, core1_resp_opaque, core1_resp_len,
					core1_resp_data);
		end
	end

	// ==========================================================
	// stimulus, always on the falling edge
	// ==========================================================
	task automatic drive_req(input int core, input req_rec_t rec);
		if (core == 0) begin
			pend_q0.push_back(rec);
			core0_req_val    = 1'b1;
			core0_req_type   = rec.typ;
			core0_req_opaque = rec.opaque;
			core0_req_addr   = rec.addr;
			core0_req_len    = rec.len;
			core0_req_data   = rec.data;
		end else begin
			pend_q1.push_back(rec);
			core1_req_val    = 1'b1;
			core1_req_type   = rec.typ;
			core1_req_opaque = rec.opaque;
			core1_req_addr   = rec.addr;
			core1_req_len    = rec.len;
			core1_req_data   = rec.data;
		end
	endtask

	task automatic step();
		@(negedge clk);
		core0_req_val = 1'b0;
		core1_req_val = 1'b0;
	endtask

	task automatic wait_idle(input int core);
		int cycles;
		cycles = 0;
		while (pending(core) != 0 && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (pending(core) != 0) begin
			$display("no response on core %0d within 20 cycles at %0t", core, $time);
			stop_run();
		end
	endtask

	task automatic access_one(input int core, input logic [2:0] typ, input logic [31:0] addr,
		input logic [1:0] len, input logic [31:0] data);
		drive_req(core, make_req(core, typ, addr, len, data));
		step();
		wait_idle(core);
	endtask

	// ==========================================================
	// test sequence
	// ==========================================================
	initial begin
		int          issued;
		int          first;
		logic [31:0] r;
		rst_n = 1'b0;
		core0_req_val = 1'b0;
		core0_req_type = '0;
		core0_req_opaque = '0;
		core0_req_addr = '0;
		core0_req_len = '0;
		core0_req_data = '0;
		core1_req_val = 1'b0;
		core1_req_type = '0;
		core1_req_opaque = '0;
		core1_req_addr = '0;
		core1_req_len = '0;
		core1_req_data = '0;
		for (int i = 0; i < `MCORE_MEM_LINES; i++)
			for (int w = 0; w < 4; w++)
				ref_lines[i].words[w] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// reads after reset, upper address bits ignored
		access_one(0, `MCORE_TYPE_READ, 32'h0000_0000, 2'd0, 32'hffff_ffff);
		access_one(1, `MCORE_TYPE_READ, 32'h0000_0044, 2'd0, 32'h0);
		access_one(0, `MCORE_TYPE_READ, 32'h1234_5678, 2'd0, 32'h0);
		access_one(1, `MCORE_TYPE_READ, 32'h0000_00fc, 2'd3, 32'h0);

		// full words
		access_one(0, `MCORE_TYPE_WRITE, 32'h0000_0010, 2'd0, 32'hdead_beef);
		access_one(1, `MCORE_TYPE_WRITE, 32'h0000_009c, 2'd0, 32'h0123_4567);
		access_one(0, `MCORE_TYPE_READ, 32'h0000_0010, 2'd0, 32'h0);
		access_one(1, `MCORE_TYPE_READ, 32'h0000_009c, 2'd0, 32'h0);
		access_one(1, `MCORE_TYPE_READ, 32'hff00_0010, 2'd0, 32'h0);

		// partial writes at unaligned offsets, then merged and masked reads
		access_one(0, `MCORE_TYPE_WRITE, 32'h0000_0020, 2'd0, 32'ha1b2_c3d4);
		access_one(0, `MCORE_TYPE_WRITE, 32'h0000_0021, 2'd1, 32'h0000_00ee);
		access_one(1, `MCORE_TYPE_WRITE, 32'h0000_002b, 2'd2, 32'h0000_7788);
		access_one(1, `MCORE_TYPE_WRITE, 32'h0000_002d, 2'd3, 32'h0066_5544);
		access_one(0, `MCORE_TYPE_READ, 32'h0000_0020, 2'd0, 32'h0);
		access_one(1, `MCORE_TYPE_READ, 32'h0000_002a, 2'd0, 32'h0);
		access_one(0, `MCORE_TYPE_READ, 32'h0000_002c, 2'd0, 32'h0);
		access_one(1, `MCORE_TYPE_READ, 32'h0000_0021, 2'd1, 32'h0);
		access_one(0, `MCORE_TYPE_READ, 32'h0000_002b, 2'd2, 32'h0);
		access_one(1, `MCORE_TYPE_READ, 32'h0000_0022, 2'd3, 32'h0);

		// both cores in the same cycle, same word, loser one cycle after the winner
		for (int i = 0; i < 8; i++) begin
			drive_req(0, make_req(0, `MCORE_TYPE_WRITE, 32'h40 + 4 * (i % 4), 2'd0,
				lcg_next()));
			drive_req(1, make_req(1, `MCORE_TYPE_READ, 32'h40 + 4 * (i % 4), 2'd0, 32'h0));
			step();
			wait_idle(0);
			wait_idle(1);
			if (resp_cycle[0] - resp_cycle[1] != 1 && resp_cycle[1] - resp_cycle[0] != 1) begin
				$display("colliding requests were not served on consecutive cycles");
				stop_run();
			end
		end

		// random mix
		issued = 0;
		while (issued < 400) begin
			r = lcg_next();
			first = int'(r[31]);
			wait_idle(first);
			drive_req(first, random_req(first));
			issued++;
			if (issued < 400 && r[30] && pending(1 - first) == 0) begin
				drive_req(1 - first, random_req(1 - first));
				issued++;
			end
			step();
		end
		wait_idle(0);
		wait_idle(1);

		if (pending(0) == 0 && pending(1) == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("requests left without a response at the end");
			stop_run();
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/proc_msg_pkg.sv
verilog/mem_msg_pkg.sv
verilog/proc2mem_trans.sv
verilog/mem_arbiter.sv
verilog/mem_bank.sv
verilog/mcore_mem_sys.sv
testbench/tb_clkgen.sv
testbench/mcore_mem_sys_chk.sv
testbench/tb_mcore_mem_sys.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mcore_mem_sys
FILELIST   := tb.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run is judged from the log, a missing verdict counts as a failure
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "CHECKS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif grep -qx "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
